/* design/audio_params.svh */
`ifndef AUDIO_PARAMS_SVH
`define AUDIO_PARAMS_SVH

// Bits carried by one audio sample, two's complement
`define AUDIO_WIDTH 24

// Bit clocks in one channel slot of the serial stream.
// Bits past AUDIO_WIDTH are padding and the receiver skips them
`define SLOT_BITS 32

// Longest running average the filter can form.
// This must be a power of two, and the delay line holds one less than this
`define LPF_MAX_TAPS 16

`endif

/* design/audio_pkg.sv */
`default_nettype none

`include "audio_params.svh"

package audio_pkg;

	// One signed audio sample as it travels from the receiver through the filters
	typedef logic signed [`AUDIO_WIDTH-1:0] sample_t;

	// Channel carried by a slot, taken from the word select level
	typedef enum logic
	{
		CH_LEFT  = 1'b0, // Word select low
		CH_RIGHT = 1'b1  // Word select high
	} channel_e;

endpackage

`default_nettype wire

/* design/filter_pkg.sv */
`default_nettype none

`include "audio_params.svh"

package filter_pkg;

	// Running-average length select, with codes 5 to 7 falling back to 16 taps
	typedef enum logic [2:0]
	{
		LPF_PASS  = 3'd0,
		LPF_AVG2  = 3'd1,
		LPF_AVG4  = 3'd2,
		LPF_AVG8  = 3'd3,
		LPF_AVG16 = 3'd4
	} filt_len_e;

	localparam int LPF_MAX_SHIFT = $clog2(`LPF_MAX_TAPS); // Shift of the longest average

	typedef logic [$clog2(LPF_MAX_SHIFT + 1)-1:0] lpf_shift_t;

	// Number of bits each term is shifted right, which is log2 of the tap count
	function automatic lpf_shift_t lpf_shift(input filt_len_e sel);
		case (sel)
			LPF_PASS: return lpf_shift_t'(0);
			LPF_AVG2: return lpf_shift_t'(1);
			LPF_AVG4: return lpf_shift_t'(2);
			LPF_AVG8: return lpf_shift_t'(3);
			default:  return lpf_shift_t'(LPF_MAX_SHIFT); // LPF_AVG16 and codes 5 to 7
		endcase
	endfunction

endpackage

`default_nettype wire

/* design/i2s_rx.sv */
`default_nettype none
`timescale 1ns/10ps

`include "audio_params.svh"

// Receiver for a left-justified serial stream, oversampled by clk.
// The MSB of a slot arrives on the first rising sck after word select changes
module i2s_rx
	import audio_pkg::*;
(
	input  logic     clk,
	input  logic     reset_n,
	input  logic     sck,
	input  logic     ws,
	input  logic     sd,
	output sample_t  rx_sample,
	output channel_e rx_channel,
	output logic     rx_valid
);

	localparam int CNT_W = $clog2(`SLOT_BITS + 1);

	localparam logic [CNT_W-1:0] LAST_DATA = CNT_W'(`AUDIO_WIDTH - 1); // Index of the LSB
	localparam logic [CNT_W-1:0] SLOT_END  = CNT_W'(`SLOT_BITS);       // Idle count

	logic                    sck_q;       // Bit clock one clk ago
	logic                    ws_q;        // Word select one clk ago
	logic                    sck_rise;
	logic                    ws_chg;
	logic                    start_pend;  // Word select moved, next rising sck opens a slot
	logic                    slot_start;
	logic                    in_slot;
	logic [CNT_W-1:0]        bit_cnt;     // Bits already taken in the current slot
	logic [CNT_W-1:0]        bit_idx;     // Position of the bit arriving now
	logic [`AUDIO_WIDTH-2:0] shift_reg;   // Data bits ahead of the LSB
	channel_e                slot_ch;

	// The serial lines are sampled every clk and compared with their last value
	always_ff @(posedge clk)
	begin
		sck_q <= sck;
		ws_q  <= ws;
	end

	assign sck_rise   = sck & ~sck_q;
	assign ws_chg     = ws ^ ws_q;
	assign slot_start = sck_rise & (start_pend | ws_chg); // A change in this same cycle counts too

	// A new slot restarts the count at zero whatever the old count was
	assign bit_idx = slot_start ? '0 : bit_cnt;
	assign in_slot = (bit_idx < SLOT_END);

	always_ff @(posedge clk)
	begin
		if (reset_n)
			start_pend <= 1'b0;
		else if (slot_start)
			start_pend <= 1'b0;
		else if (ws_chg)
			start_pend <= 1'b1; // Held until the bit clock rises
	end

	// After reset the counter sits at the idle count, so nothing is captured
	// until word select changes and a full slot begins
	always_ff @(posedge clk)
	begin
		if (reset_n)
		begin
			bit_cnt <= SLOT_END;
			slot_ch <= CH_LEFT;
		end
		else
		begin
			if (sck_rise && in_slot)
				bit_cnt <= bit_idx + 1'b1; // Stops at the idle count once the slot is done
			if (slot_start)
				slot_ch <= channel_e'(ws);
		end
	end

	// Every data bit before the LSB goes through the shift register, MSB first
	always_ff @(posedge clk)
	begin
		if (sck_rise && (bit_idx < LAST_DATA))
			shift_reg <= {shift_reg[`AUDIO_WIDTH-3:0], sd};
	end

	// The LSB is joined straight to the shifted bits, so the word is out one clk
	// after its last bit is seen
	always_ff @(posedge clk)
	begin
		if (reset_n)
		begin
			rx_valid   <= 1'b0;
			rx_sample  <= '0;
			rx_channel <= CH_LEFT;
		end
		else
		begin
			rx_valid <= sck_rise && (bit_idx == LAST_DATA);
			if (sck_rise && (bit_idx == LAST_DATA))
			begin
				rx_sample  <= {shift_reg, sd};
				rx_channel <= slot_ch;
			end
		end
	end

	// One word per slot, so the strobe can never last two clk
	a_valid_single: assert property (@(posedge clk) disable iff (reset_n)
		rx_valid |=> !rx_valid)
		else $error("rx_valid held high for two cycles");

endmodule

`default_nettype wire

/* design/moving_avg_lpf.sv */
`default_nettype none
`timescale 1ns/10ps

`include "audio_params.svh"

// Running-average low-pass filter over 1, 2, 4, 8 or 16 samples.
// Each term is shifted down before the sum, so the result can never overflow
module moving_avg_lpf
	import audio_pkg::*, filter_pkg::*;
#(
	parameter int WIDTH = $bits(sample_t)
)(
	input  logic                    clk,
	input  logic                    reset_n,
	input  logic                    en,       // One strobe per new sample of this channel
	input  filt_len_e               filt_sel,
	input  logic signed [WIDTH-1:0] d,
	output logic signed [WIDTH-1:0] q
);

	localparam int DEPTH = `LPF_MAX_TAPS - 1; // History kept besides the current sample

	logic signed [WIDTH-1:0] del [DEPTH]; // del[0] is the newest previous sample
	logic signed [WIDTH-1:0] avg;
	lpf_shift_t              shift;
	int                      taps;

	assign shift = lpf_shift(filt_sel);

	// The current sample always contributes, then as many history entries
	// as the selected length needs. An arithmetic shift floors each term,
	// so odd negative samples lose their fraction toward minus infinity
	always_comb
	begin
		taps = 1 << shift;
		avg  = d >>> shift;
		for (int j = 0; j < DEPTH; j++)
		begin
			if (j < taps - 1)
				avg = avg + (del[j] >>> shift);
		end
	end

	// The delay line moves only when this channel has a new sample.
	// It is kept full at every length, so a select change uses it at once
	always_ff @(posedge clk)
	begin
		if (reset_n)
		begin
			for (int i = 0; i < DEPTH; i++)
			begin
				del[i] <= '0;
			end
		end
		else if (en)
		begin
			del[0] <= d;
			for (int i = 1; i < DEPTH; i++)
			begin
				del[i] <= del[i-1];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset_n)
			q <= '0;
		else if (en)
			q <= avg; // Holds between samples
	end

	// An unknown select would pick an arbitrary tap count on a live sample
	a_sel_known: assert property (@(posedge clk) disable iff (reset_n)
		en |-> !$isunknown(filt_sel))
		else $error("filt_sel unknown while a sample is filtered");

endmodule

`default_nettype wire

/* design/stereo_lpf.sv */
`default_nettype none
`timescale 1ns/10ps

// Stereo low-pass stage: serial receiver followed by one averaging filter per channel.
// q_left updates during the frame, q_right and q_valid mark the frame as complete
module stereo_lpf
	import audio_pkg::*, filter_pkg::*;
(
	input  logic      clk,
	input  logic      reset_n,
	input  logic      sck,
	input  logic      ws,
	input  logic      sd,
	input  filt_len_e filt_sel,  // Applies to both channels
	output sample_t   q_left,
	output sample_t   q_right,
	output logic      q_valid
);

	sample_t  rx_sample;
	channel_e rx_channel;
	logic     rx_valid;
	logic     en_left;
	logic     en_right;

	i2s_rx u_rx
	(
		.clk        (clk),
		.reset_n    (reset_n),
		.sck        (sck),
		.ws         (ws),
		.sd         (sd),
		.rx_sample  (rx_sample),
		.rx_channel (rx_channel),
		.rx_valid   (rx_valid)
	);

	// Each filter sees only the samples of its own channel
	assign en_left  = rx_valid && (rx_channel == CH_LEFT);
	assign en_right = rx_valid && (rx_channel == CH_RIGHT);

	moving_avg_lpf #(.WIDTH($bits(sample_t))) u_lpf_left
	(
		.clk      (clk),
		.reset_n  (reset_n),
		.en       (en_left),
		.filt_sel (filt_sel),
		.d        (rx_sample),
		.q        (q_left)
	);

	moving_avg_lpf #(.WIDTH($bits(sample_t))) u_lpf_right
	(
		.clk      (clk),
		.reset_n  (reset_n),
		.en       (en_right),
		.filt_sel (filt_sel),
		.d        (rx_sample),
		.q        (q_right)
	);

	// The right slot closes the frame. Delaying its enable by one clk lines
	// the strobe up with the cycle in which the new q_right appears
	always_ff @(posedge clk)
	begin
		if (reset_n)
			q_valid <= 1'b0;
		else
			q_valid <= en_right;
	end

endmodule

`default_nettype wire

/* tb/tb_clock.sv */
`default_nettype none
`timescale 1ns/10ps

// Free-running testbench clock that starts low
module tb_clock
#(
	parameter int PERIOD_NS = 20
)(
	output logic clk
);

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#(PERIOD_NS / 2) clk = ~clk;
		end
	end

endmodule

`default_nettype wire

/* tb/stereo_lpf_tb.sv */
`default_nettype none
`timescale 1ns/10ps

`include "audio_params.svh"

module stereo_lpf_tb
	import audio_pkg::*, filter_pkg::*;
();

	localparam int    CLK_PERIOD_NS = 20;
	localparam int    SCK_HALF      = 4;              // clk cycles per half period of sck
	localparam int    RESET_CYCLES  = 10;
	localparam int    VALID_TIMEOUT = 4 * SCK_HALF * 2;
	localparam string GOLDEN_FILE   = "tb/lpf_golden.dat";

	logic      clk;
	logic      reset_n;
	logic      sck;
	logic      ws;
	logic      sd;
	filt_len_e filt_sel;
	sample_t   q_left;
	sample_t   q_right;
	logic      q_valid;

	// Golden entries in file order, each one a test marker or a frame
	bit         ent_is_test [$];
	bit         ent_reset   [$];
	string      ent_name    [$];
	logic [2:0] ent_sel     [$];
	sample_t    ent_left    [$];
	sample_t    ent_right   [$];
	sample_t    ent_exp_l   [$];
	sample_t    ent_exp_r   [$];

	int      frame_total;
	int      frames_sent;
	int      frames_seen = 0; // Counted by the output monitor only
	sample_t cap_left;
	sample_t cap_right;
	int      pass_count;
	int      fail_count;
	int      test_count;
	string   cur_name;
	int      cur_frames;
	int      cur_errs;
	bit      test_open;
	bit      loaded_ok;
	longint  watch_ns = 0;

	tb_clock #(.PERIOD_NS(CLK_PERIOD_NS)) u_clock (.clk(clk));

	stereo_lpf uut
	(
		.clk      (clk),
		.reset_n  (reset_n),
		.sck      (sck),
		.ws       (ws),
		.sd       (sd),
		.filt_sel (filt_sel),
		.q_left   (q_left),
		.q_right  (q_right),
		.q_valid  (q_valid)
	);

	// q_valid lasts one clk, so a single falling edge sees each frame
	always @(negedge clk)
	begin
		if (q_valid)
		begin
			cap_left    <= q_left;
			cap_right   <= q_right;
			frames_seen <= frames_seen + 1;
		end
	end

	function automatic void add_entry(input bit is_test, input bit rst, input string nm,
		input logic [2:0] sel, input sample_t l, input sample_t r,
		input sample_t el, input sample_t er);
		ent_is_test.push_back(is_test);
		ent_reset.push_back(rst);
		ent_name.push_back(nm);
		ent_sel.push_back(sel);
		ent_left.push_back(l);
		ent_right.push_back(r);
		ent_exp_l.push_back(el);
		ent_exp_r.push_back(er);
	endfunction

	task automatic load_golden(output bit ok);
		int         fd;
		int         cnt;
		int         rst;
		string      line;
		string      nm;
		logic [2:0] sel;
		sample_t    l;
		sample_t    r;
		sample_t    el;
		sample_t    er;
		ok = 1'b1;
		frame_total = 0;
		fd = $fopen(GOLDEN_FILE, "r");
		if (fd == 0)
		begin
			$display("Cannot open the golden file %s", GOLDEN_FILE);
			ok = 1'b0;
		end
		else
		begin
			while ($fgets(line, fd) != 0)
			begin
				if (line.len() > 0 && line.getc(0) == "T")
				begin
					cnt = $sscanf(line, "T %d %s", rst, nm);
					if (cnt != 2)
					begin
						$display("Malformed line in the golden file: %s", line);
						ok = 1'b0;
					end
					else
						add_entry(1'b1, rst != 0, nm, '0, '0, '0, '0, '0);
				end
				else if (line.len() > 0 && line.getc(0) == "F")
				begin
					cnt = $sscanf(line, "F %h %h %h %h %h", sel, l, r, el, er);
					if (cnt != 5)
					begin
						$display("Malformed line in the golden file: %s", line);
						ok = 1'b0;
					end
					else
					begin
						add_entry(1'b0, 1'b0, "", sel, l, r, el, er);
						frame_total++;
					end
				end
			end
			$fclose(fd);
			if (frame_total == 0)
			begin
				$display("The golden file holds no frames");
				ok = 1'b0;
			end
		end
	endtask

	task automatic check_value(input string sig, input sample_t expected, input sample_t actual);
		if (actual !== expected)
		begin
			$display("ERR %0t ns %s expected %06h actual %06h", $time, sig, expected, actual);
			fail_count++;
			cur_errs++;
		end
		else
			pass_count++;
	endtask

	task automatic apply_reset();
		@(negedge clk);
		reset_n = 1'b1; // Reset is active while high
		sck     = 1'b0;
		ws      = 1'b1;
		sd      = 1'b0;
		repeat (RESET_CYCLES) @(negedge clk);
		reset_n = 1'b0;
	endtask

	// One slot, MSB first and zero-padded past the sample width.
	// Word select and data only move while sck is low
	task automatic drive_slot(input channel_e ch, input sample_t word);
		logic [`SLOT_BITS-1:0] bits;
		bits = {word, {(`SLOT_BITS - `AUDIO_WIDTH){1'b0}}};
		ws   = ch;
		for (int b = 0; b < `SLOT_BITS; b++)
		begin
			sck  = 1'b0;
			sd   = bits[`SLOT_BITS-1];
			bits = bits << 1;
			repeat (SCK_HALF) @(negedge clk);
			sck = 1'b1;
			repeat (SCK_HALF) @(negedge clk);
		end
	endtask

	task automatic run_frame(input int n);
		int waited;
		filt_sel = filt_len_e'(ent_sel[n]);
		drive_slot(CH_LEFT, ent_left[n]);
		drive_slot(CH_RIGHT, ent_right[n]);
		frames_sent++;
		waited = 0;
		while (frames_seen < frames_sent && waited < VALID_TIMEOUT)
		begin
			@(negedge clk);
			waited++;
		end
		if (frames_seen != frames_sent)
		begin
			if (frames_seen < frames_sent)
				$display("No q_valid came for frame %0d of test %s", cur_frames, cur_name);
			else
				$display("More than one q_valid in frame %0d of test %s", cur_frames, cur_name);
			fail_count++;
			cur_errs++;
			frames_sent = frames_seen; // Later frames are still checked one by one
		end
		else
		begin
			check_value("q_left", ent_exp_l[n], cap_left);
			check_value("q_right", ent_exp_r[n], cap_right);
		end
		cur_frames++;
	endtask

	task automatic close_test();
		if (test_open)
		begin
			$display("Test %s: %0d frames, %0d errors, %s", cur_name, cur_frames, cur_errs,
				(cur_errs == 0) ? "ok" : "FAILED");
			test_count++;
		end
		test_open = 1'b0;
	endtask

	initial
	begin
		reset_n     = 1'b1;
		sck         = 1'b0;
		ws          = 1'b1;
		sd          = 1'b0;
		filt_sel    = LPF_PASS;
		frames_sent = 0;
		pass_count  = 0;
		fail_count  = 0;
		test_count  = 0;
		test_open   = 1'b0;
		cur_name    = "unnamed";
		cur_frames  = 0;
		cur_errs    = 0;
		load_golden(loaded_ok);
		if (!loaded_ok)
		begin
			$display("Verification failed");
			$finish;
		end
		else
		begin
			watch_ns = longint'(frame_total + 4) * 2 * `SLOT_BITS * 2 * SCK_HALF
				* CLK_PERIOD_NS * 2;
			apply_reset();
			for (int n = 0; n < ent_is_test.size(); n++)
			begin
				if (ent_is_test[n])
				begin
					close_test();
					cur_name   = ent_name[n];
					cur_frames = 0;
					cur_errs   = 0;
					test_open  = 1'b1;
					if (ent_reset[n])
						apply_reset();
				end
				else
				begin
					test_open = 1'b1; // Frames ahead of any marker count as one test
					run_frame(n);
				end
			end
			close_test();
			$display("Summary: %0d tests, %0d checks passed, %0d failed",
				test_count, pass_count, fail_count);
			if (fail_count == 0 && pass_count > 0)
				$display("Verification passed");
			else
				$display("Verification failed");
			$finish;
		end
	end

	// Twice the time that the frames of the golden file should take
	initial
	begin
		wait (watch_ns > 0);
		#(watch_ns);
		$display("Timeout: the run did not finish within %0d ns", watch_ns);
		$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

/* tb/lpf_golden.dat */
# T <reset before the test, 0 or 1> <test name>
# F <filt_sel> <left in> <right in> <expected q_left> <expected q_right>, all hex

T 1 pass_through
F 0 123456 654321 123456 654321
F 0 7FFFFF 800000 7FFFFF 800000
F 0 FFFFFF 000001 FFFFFF 000001
F 0 A5A5A5 5A5A5A A5A5A5 5A5A5A

T 1 avg2_floor
F 1 000010 FFFFFF 000008 FFFFFF
F 1 FFFFFF FFFFFF 000007 FFFFFE
F 1 FFFFFD 000003 FFFFFD 000000
F 1 000005 FFFFF9 000000 FFFFFD

T 1 avg4_step_alt
F 2 000400 000400 000100 000100
F 2 000400 FFFC00 000200 000000
F 2 000400 000400 000300 000100
F 2 000400 FFFC00 000400 000000
F 2 000400 000400 000400 000000

T 1 avg8_step_alt
F 3 000800 000008 000100 000001
F 3 000800 FFFFF7 000200 FFFFFF
F 3 000800 000008 000300 000000
F 3 000800 FFFFF7 000400 FFFFFE
F 3 000800 000008 000500 FFFFFF
F 3 000800 FFFFF7 000600 FFFFFD
F 3 000800 000008 000700 FFFFFE
F 3 000800 FFFFF7 000800 FFFFFC
F 3 000800 000008 000800 FFFFFC

T 1 avg16_alias_full_scale
F 4 7FFFFF 800000 07FFFF F80000
F 5 7FFFFF 800000 0FFFFE F00000
F 6 7FFFFF 800000 17FFFD E80000
F 7 7FFFFF 800000 1FFFFC E00000
F 4 7FFFFF 800000 27FFFB D80000
F 5 7FFFFF 800000 2FFFFA D00000
F 6 7FFFFF 800000 37FFF9 C80000
F 7 7FFFFF 800000 3FFFF8 C00000
F 4 7FFFFF 800000 47FFF7 B80000
F 5 7FFFFF 800000 4FFFF6 B00000
F 6 7FFFFF 800000 57FFF5 A80000
F 7 7FFFFF 800000 5FFFF4 A00000
F 4 7FFFFF 800000 67FFF3 980000
F 5 7FFFFF 800000 6FFFF2 900000
F 6 7FFFFF 800000 77FFF1 880000
F 7 7FFFFF 800000 7FFFF0 800000
F 4 7FFFFF 800000 7FFFF0 800000

T 1 reset_clears
F 4 000100 FFFF00 000010 FFFFF0
F 4 000100 FFFF00 000020 FFFFE0
F 4 000100 FFFF00 000030 FFFFD0

T 0 sel_change
F 1 000400 FFFC00 000280 FFFD80
F 4 000400 FFFC00 0000B0 FFFF50
F 2 000000 000000 000240 FFFDC0
F 0 000123 FFFEDD 000123 FFFEDD
F 3 000000 000000 000184 FFFE7B

/* sources.f */
+incdir+design
design/audio_pkg.sv
design/filter_pkg.sv
design/i2s_rx.sv
design/moving_avg_lpf.sv
design/stereo_lpf.sv
tb/tb_clock.sv
tb/stereo_lpf_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the stereo low-pass testbench with Verilator and runs it.
# Exits 0 only when the run prints the pass line.

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
	echo "Cannot change to the project directory"
	exit 1
fi

verilator --binary --assert --top-module stereo_lpf_tb -Mdir obj_dir -f sources.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vstereo_lpf_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

printf '%s\n' "$out" | grep -qx "Verification passed"
if [ $? -ne 0 ]; then
	exit 1
fi
exit 0
